// File: logic/ecc_icon_defs.svh
// ECC interconnect sizing macros
`ifndef ECC_ICON_DEFS_SVH
`define ECC_ICON_DEFS_SVH

// Initiator side
`define ECC_N_INIT 4   // Initiator ports

// Memory side
`define ECC_N_BANK 4   // Word-interleaved banks
`define ECC_ROWS   16  // Words per bank

// Word format
`define ECC_DATA_W 32  // Payload bits
`define ECC_PAR_W  7   // Six Hamming bits plus overall parity

// Error bookkeeping
`define ECC_CNT_W  16  // Saturating counter width

`endif

// File: logic/ecc_icon_pkg.sv
// ECC interconnect shared types
`include "ecc_icon_defs.svh"

package ecc_icon_pkg;

  localparam int unsigned BANK_W = $clog2(`ECC_N_BANK);           // Bank select bits
  localparam int unsigned ROW_W  = $clog2(`ECC_ROWS);             // Row bits per bank
  localparam int unsigned ID_W   = $clog2(`ECC_N_INIT);           // Initiator index bits
  localparam int unsigned ADDR_W = ROW_W + BANK_W;                // Word address bits
  localparam int unsigned CODE_W = `ECC_DATA_W + `ECC_PAR_W;      // Stored word bits

  typedef logic [`ECC_DATA_W-1:0] data_t;     // One payload word
  typedef logic [CODE_W-1:0]      code_t;     // SECDED code word as stored
  typedef logic [ADDR_W-1:0]      addr_t;     // {row, bank}
  typedef logic [BANK_W-1:0]      bank_sel_t; // Low address bits
  typedef logic [ROW_W-1:0]       row_t;      // High address bits
  typedef logic [ID_W-1:0]        init_id_t;  // Routes the read response back
  typedef logic [`ECC_CNT_W-1:0]  err_cnt_t;  // One error counter

endpackage

// File: logic/ecc_xbar_req.sv
// Request crossbar with per-bank round robin
`timescale 1ns/1ns
`include "ecc_icon_defs.svh"

module ecc_xbar_req
  import ecc_icon_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Initiator side
  input  logic      [`ECC_N_INIT-1:0]         req_i,
  input  logic      [`ECC_N_INIT-1:0]         wen_i,        // High for a read
  input  addr_t     [`ECC_N_INIT-1:0]         addr_i,
  input  data_t     [`ECC_N_INIT-1:0]         wdata_i,
  output logic      [`ECC_N_INIT-1:0]         gnt_o,
  // Bank side
  output logic      [`ECC_N_BANK-1:0]         bank_req_o,   // Accepted request strobe
  output logic      [`ECC_N_BANK-1:0]         bank_wen_o,
  output row_t      [`ECC_N_BANK-1:0]         bank_row_o,
  output data_t     [`ECC_N_BANK-1:0]         bank_wdata_o,
  output init_id_t  [`ECC_N_BANK-1:0]         bank_id_o
);

  logic     [`ECC_N_BANK-1:0][`ECC_N_INIT-1:0] bank_hit; // Who targets which bank
  init_id_t [`ECC_N_BANK-1:0]                  rr_q;     // Highest priority per bank
  init_id_t [`ECC_N_BANK-1:0]                  win_id;   // Chosen requester
  logic     [`ECC_N_BANK-1:0]                  win_vld;  // Bank has a winner

  // Address decode, bank index sits in the low word address bits
  always_comb begin
    for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
      for (int unsigned i = 0; i < `ECC_N_INIT; i++) begin
        bank_hit[b][i] = req_i[i] && (addr_i[i][BANK_W-1:0] == bank_sel_t'(b)); // Match
      end
    end
  end

  // Round-robin pick, search starts at the pointer and wraps
  always_comb begin
    init_id_t idx;
    for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
      win_vld[b] = 1'b0;
      win_id[b]  = rr_q[b];                         // Default keeps muxes quiet
      for (int unsigned k = 0; k < `ECC_N_INIT; k++) begin
        idx = init_id_t'(rr_q[b] + k);              // Wraps modulo port count
        if (!win_vld[b] && bank_hit[b][idx]) begin
          win_vld[b] = 1'b1;                        // First hit wins
          win_id[b]  = idx;
        end
      end
    end
  end

  // Grant back to the winners only
  always_comb begin
    gnt_o = '0;
    for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
      if (win_vld[b]) begin
        gnt_o[win_id[b]] = 1'b1;                    // One bank per initiator at most
      end
    end
  end

  // Forward the winning request fields
  always_comb begin
    for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
      bank_req_o[b]   = win_vld[b];                         // Req and gnt both high
      bank_wen_o[b]   = wen_i[win_id[b]];
      bank_row_o[b]   = addr_i[win_id[b]][ADDR_W-1:BANK_W]; // Drop bank bits
      bank_wdata_o[b] = wdata_i[win_id[b]];
      bank_id_o[b]    = win_id[b];                          // Tag for the response
    end
  end

  // Pointer moves past the winner on every accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
        if (win_vld[b]) begin
          rr_q[b] <= init_id_t'(win_id[b] + 1'b1);  // Loser gets priority next
        end
      end
    end
  end

endmodule

// File: logic/ecc_bank.sv
// SECDED protected memory bank
`timescale 1ns/1ns
`include "ecc_icon_defs.svh"

module ecc_bank
  import ecc_icon_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,         // Accepted request strobe
  input  logic     wen_i,         // High for a read
  input  row_t     row_i,
  input  data_t    wdata_i,
  input  init_id_t id_i,
  input  code_t    inj_mask_i,    // Flips stored bits on write
  output logic     rvalid_o,
  output data_t    rdata_o,
  output init_id_t rid_o,
  output logic     single_err_o,
  output logic     multi_err_o
);

  localparam int unsigned HAM_W = `ECC_PAR_W - 1; // Hamming bits without overall parity

  // Code word layout: bit 0 overall parity, bits 1..38 in Hamming position order,
  // check bits at the powers of two, data in the remaining slots
  code_t            mem_q [`ECC_ROWS];  // Storage array
  code_t            rd_cw_q;            // Word under decode
  init_id_t         rid_q;
  logic             rvalid_q;
  code_t            wr_cw;              // Encoded write word
  logic [HAM_W-1:0] syndrome;
  logic             syn_nz;
  logic             par_fail;           // Overall parity broken
  code_t            fixed_cw;           // After single-bit correction

  function automatic code_t ecc_encode(data_t data);
    code_t       cw;
    int unsigned k;
    logic        acc;
    cw = '0;
    k  = 0;
    for (int unsigned p = 1; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin     // Not a power of two
        cw[p] = data[k];
        k++;
      end
    end
    for (int unsigned j = 0; j < HAM_W; j++) begin
      acc = 1'b0;
      for (int unsigned p = 1; p < CODE_W; p++) begin
        if (((p >> j) & 1) != 0) acc ^= cw[p];
      end
      cw[1 << j] = acc;                 // Check bit j covers positions with bit j set
    end
    cw[0] = ^cw[CODE_W-1:1];            // Overall parity for double detection
    return cw;
  endfunction

  function automatic logic [HAM_W-1:0] ecc_syndrome(code_t cw);
    logic [HAM_W-1:0] syn;
    syn = '0;
    for (int unsigned j = 0; j < HAM_W; j++) begin
      for (int unsigned p = 1; p < CODE_W; p++) begin
        if (((p >> j) & 1) != 0) syn[j] ^= cw[p];
      end
    end
    return syn;                         // Position of a single flip
  endfunction

  function automatic data_t ecc_extract(code_t cw);
    data_t       data;
    int unsigned k;
    data = '0;
    k    = 0;
    for (int unsigned p = 1; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        data[k] = cw[p];                // Same slot order as encode
        k++;
      end
    end
    return data;
  endfunction

  assign wr_cw = ecc_encode(wdata_i);

  // Write lands at the accepting edge, mask applied here
  always_ff @(posedge clk_i) begin
    if (req_i && !wen_i) begin
      mem_q[row_i] <= wr_cw ^ inj_mask_i;
    end
  end

  // Read payload capture
  always_ff @(posedge clk_i) begin
    if (req_i && wen_i) begin
      rd_cw_q <= mem_q[row_i];
      rid_q   <= id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i && wen_i;       // Reads only
    end
  end

  // Decode in the cycle after the read edge
  assign syndrome = ecc_syndrome(rd_cw_q);
  assign syn_nz   = |syndrome;
  assign par_fail = ^rd_cw_q;           // Odd number of flips

  always_comb begin
    fixed_cw = rd_cw_q;
    if (syn_nz && par_fail && (syndrome < CODE_W)) begin
      fixed_cw[syndrome] = ~rd_cw_q[syndrome];  // Flip the bad bit back
    end
  end

  assign rvalid_o     = rvalid_q;
  assign rdata_o      = ecc_extract(fixed_cw);
  assign rid_o        = rid_q;
  assign single_err_o = rvalid_q && syn_nz && par_fail;   // Correctable
  assign multi_err_o  = rvalid_q && syn_nz && !par_fail;  // Double flip detected

endmodule

// File: logic/ecc_resp_collect.sv
// Response routing and ECC error counters
`timescale 1ns/1ns
`include "ecc_icon_defs.svh"

module ecc_resp_collect
  import ecc_icon_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Bank side
  input  logic     [`ECC_N_BANK-1:0]       bank_rvalid_i,
  input  data_t    [`ECC_N_BANK-1:0]       bank_rdata_i,
  input  init_id_t [`ECC_N_BANK-1:0]       bank_rid_i,
  input  logic     [`ECC_N_BANK-1:0]       bank_single_err_i,
  input  logic     [`ECC_N_BANK-1:0]       bank_multi_err_i,
  // Counter access
  input  logic                             cnt_sel_i,  // 0 correctable, 1 uncorrectable
  input  logic                             cnt_clr_i,  // Clears both
  // Initiator side
  output logic     [`ECC_N_INIT-1:0]       r_valid_o,
  output data_t    [`ECC_N_INIT-1:0]       r_rdata_o,
  output err_cnt_t                         cnt_o
);

  localparam int unsigned INC_W = $clog2(`ECC_N_BANK + 1); // Up to all banks at once

  logic [INC_W-1:0] n_single;     // Banks with a corrected error this cycle
  logic [INC_W-1:0] n_multi;      // Banks with an uncorrectable error
  err_cnt_t         corr_cnt_q;
  err_cnt_t         uncorr_cnt_q;

  function automatic err_cnt_t sat_add(err_cnt_t cnt, logic [INC_W-1:0] inc);
    logic [`ECC_CNT_W:0] sum;
    sum = {1'b0, cnt} + inc;
    return sum[`ECC_CNT_W] ? '1 : sum[`ECC_CNT_W-1:0];  // Stick at all ones
  endfunction

  // Steer responses by ID, each initiator owns at most one bank per cycle
  always_comb begin
    r_valid_o = '0;
    r_rdata_o = '0;
    for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
      if (bank_rvalid_i[b]) begin
        r_valid_o[bank_rid_i[b]] = 1'b1;
        r_rdata_o[bank_rid_i[b]] = bank_rdata_i[b];
      end
    end
  end

  // Error population count, flags only count with their response
  always_comb begin
    n_single = '0;
    n_multi  = '0;
    for (int unsigned b = 0; b < `ECC_N_BANK; b++) begin
      n_single += INC_W'(bank_rvalid_i[b] & bank_single_err_i[b]);
      n_multi  += INC_W'(bank_rvalid_i[b] & bank_multi_err_i[b]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      corr_cnt_q   <= '0;
      uncorr_cnt_q <= '0;
    end else if (cnt_clr_i) begin
      corr_cnt_q   <= '0;                              // Clear beats increment
      uncorr_cnt_q <= '0;
    end else begin
      corr_cnt_q   <= sat_add(corr_cnt_q, n_single);
      uncorr_cnt_q <= sat_add(uncorr_cnt_q, n_multi);
    end
  end

  assign cnt_o = cnt_sel_i ? uncorr_cnt_q : corr_cnt_q; // Readback mux

endmodule

// File: logic/ecc_icon_top.sv
// ECC shared-memory interconnect top
`timescale 1ns/1ns
`include "ecc_icon_defs.svh"

module ecc_icon_top
  import ecc_icon_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Initiator ports
  input  logic     [`ECC_N_INIT-1:0]   req_i,
  input  logic     [`ECC_N_INIT-1:0]   wen_i,       // High for a read
  input  addr_t    [`ECC_N_INIT-1:0]   addr_i,
  input  data_t    [`ECC_N_INIT-1:0]   wdata_i,
  output logic     [`ECC_N_INIT-1:0]   gnt_o,
  output logic     [`ECC_N_INIT-1:0]   r_valid_o,
  output data_t    [`ECC_N_INIT-1:0]   r_rdata_o,
  // Fault injection, shared by all banks
  input  code_t                        inj_mask_i,
  // Error counter access
  input  logic                         cnt_sel_i,
  input  logic                         cnt_clr_i,
  output err_cnt_t                     cnt_o
);

  // Crossbar to banks
  logic     [`ECC_N_BANK-1:0] bank_req;
  logic     [`ECC_N_BANK-1:0] bank_wen;
  row_t     [`ECC_N_BANK-1:0] bank_row;
  data_t    [`ECC_N_BANK-1:0] bank_wdata;
  init_id_t [`ECC_N_BANK-1:0] bank_id;

  // Banks to response collector
  logic     [`ECC_N_BANK-1:0] bank_rvalid;
  data_t    [`ECC_N_BANK-1:0] bank_rdata;
  init_id_t [`ECC_N_BANK-1:0] bank_rid;
  logic     [`ECC_N_BANK-1:0] bank_single_err;
  logic     [`ECC_N_BANK-1:0] bank_multi_err;

  ecc_xbar_req i_ecc_xbar_req (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( req_i      ),
    .wen_i        ( wen_i      ),
    .addr_i       ( addr_i     ),
    .wdata_i      ( wdata_i    ),
    .gnt_o        ( gnt_o      ),
    .bank_req_o   ( bank_req   ),
    .bank_wen_o   ( bank_wen   ),
    .bank_row_o   ( bank_row   ),
    .bank_wdata_o ( bank_wdata ),
    .bank_id_o    ( bank_id    )
  );

  for (genvar b = 0; b < `ECC_N_BANK; b++) begin : gen_bank
    ecc_bank i_ecc_bank (
      .clk_i        ( clk_i              ),
      .rst_ni       ( rst_ni             ),
      .req_i        ( bank_req[b]        ),
      .wen_i        ( bank_wen[b]        ),
      .row_i        ( bank_row[b]        ),
      .wdata_i      ( bank_wdata[b]      ),
      .id_i         ( bank_id[b]         ),
      .inj_mask_i   ( inj_mask_i         ),
      .rvalid_o     ( bank_rvalid[b]     ),
      .rdata_o      ( bank_rdata[b]      ),
      .rid_o        ( bank_rid[b]        ),
      .single_err_o ( bank_single_err[b] ),
      .multi_err_o  ( bank_multi_err[b]  )
    );
  end

  ecc_resp_collect i_ecc_resp_collect (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .bank_rvalid_i     ( bank_rvalid     ),
    .bank_rdata_i      ( bank_rdata      ),
    .bank_rid_i        ( bank_rid        ),
    .bank_single_err_i ( bank_single_err ),
    .bank_multi_err_i  ( bank_multi_err  ),
    .cnt_sel_i         ( cnt_sel_i       ),
    .cnt_clr_i         ( cnt_clr_i       ),
    .r_valid_o         ( r_valid_o       ),
    .r_rdata_o         ( r_rdata_o       ),
    .cnt_o             ( cnt_o           )
  );

endmodule

// File: tb/ecc_icon_chk.sv
// Interconnect protocol assertions
`timescale 1ns/1ns
`include "ecc_icon_defs.svh"

module ecc_icon_chk
  import ecc_icon_pkg::*;
(
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic  [`ECC_N_INIT-1:0]        req_i,
  input logic  [`ECC_N_INIT-1:0]        wen_i,
  input addr_t [`ECC_N_INIT-1:0]        addr_i,
  input logic  [`ECC_N_INIT-1:0]        gnt_i,
  input logic  [`ECC_N_INIT-1:0]        r_valid_i
);

  int unsigned            fail_cnt = 0; // Failed assertion count
  logic [`ECC_N_INIT-1:0] rd_acc;       // Reads accepted this cycle
  logic                   clash;        // Two grants on one bank

  assign rd_acc = req_i & gnt_i & wen_i;

  always_comb begin
    clash = 1'b0;
    for (int i = 0; i < `ECC_N_INIT; i++) begin
      for (int j = i + 1; j < `ECC_N_INIT; j++) begin
        if (gnt_i[i] && gnt_i[j] && (addr_i[i][BANK_W-1:0] == addr_i[j][BANK_W-1:0])) begin
          clash = 1'b1;                 // Same bank bits
        end
      end
    end
  end

  a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni) (gnt_i & ~req_i) == '0)
    else begin
      $error("grant without request");
      fail_cnt++;
    end
  a_bank_excl: assert property (@(posedge clk_i) disable iff (!rst_ni) !clash)
    else begin
      $error("bank granted twice");
      fail_cnt++;
    end
  a_rd_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_acc != '0 |=> (r_valid_i & $past(rd_acc)) == $past(rd_acc))
    else begin
      $error("read without response");
      fail_cnt++;
    end
  a_no_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_i & ~$past(rd_acc)) == '0)
    else begin
      $error("response without read");
      fail_cnt++;
    end

endmodule

bind ecc_icon_top ecc_icon_chk i_ecc_icon_chk (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .req_i     ( req_i     ),
  .wen_i     ( wen_i     ),
  .addr_i    ( addr_i    ),
  .gnt_i     ( gnt_o     ),
  .r_valid_i ( r_valid_o )
);

// File: tb/tb_ecc_icon_top.sv
// ECC interconnect testbench
`timescale 1ns/1ns
`include "ecc_icon_defs.svh"

module tb_ecc_icon_top
  import ecc_icon_pkg::*;
();

  localparam int MAX_VEC = 64;
  localparam int OP_WR   = 0;
  localparam int OP_RD   = 1;
  localparam int OP_RDX  = 2;   // Read without data compare
  localparam int OP_CNT  = 3;
  localparam int OP_CLR  = 4;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic     [`ECC_N_INIT-1:0]    req, wen, gnt, r_valid;
  addr_t    [`ECC_N_INIT-1:0]    addr;
  data_t    [`ECC_N_INIT-1:0]    wdata, r_rdata;
  code_t                         inj_mask;
  logic                          cnt_sel, cnt_clr;
  err_cnt_t                      cnt;

  int                            n_vec = 0;
  int                            v_test [MAX_VEC];
  int                            v_op   [MAX_VEC];
  logic     [`ECC_N_INIT-1:0]    v_mask [MAX_VEC];
  addr_t    [`ECC_N_INIT-1:0]    v_addr [MAX_VEC];
  data_t    [`ECC_N_INIT-1:0]    v_data [MAX_VEC];
  code_t                         v_inj  [MAX_VEC];
  int                            v_exp  [MAX_VEC];   // Grant cycles or counter value
  int                            errors = 0;
  int                            n_tests = 0, n_failed = 0;
  int                            cur_test, test_start;

  ecc_icon_top i_ecc_icon_top (
    .clk_i      ( clk      ),
    .rst_ni     ( rst_n    ),
    .req_i      ( req      ),
    .wen_i      ( wen      ),
    .addr_i     ( addr     ),
    .wdata_i    ( wdata    ),
    .gnt_o      ( gnt      ),
    .r_valid_o  ( r_valid  ),
    .r_rdata_o  ( r_rdata  ),
    .inj_mask_i ( inj_mask ),
    .cnt_sel_i  ( cnt_sel  ),
    .cnt_clr_i  ( cnt_clr  ),
    .cnt_o      ( cnt      )
  );

  always #10 clk = ~clk;   // 20 ns period

  function automatic int total_errors();
    return errors + int'(i_ecc_icon_top.i_ecc_icon_chk.fail_cnt);  // Bound checker too
  endfunction

  task automatic load_vectors();
    int          fd, n, t, op;
    string       line;
    logic [31:0] m, a0, a1, a2, a3, d0, d1, d2, d3, ex;
    logic [63:0] inj;
    fd = $fopen("tb/ecc_icon_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file tb/ecc_icon_stim.txt could not be opened");
      return;
    end
    while (!$feof(fd) && n_vec < MAX_VEC) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line[0] == "#") continue;   // Column legend
      n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h",
                  t, op, m, a0, a1, a2, a3, d0, d1, d2, d3, inj, ex);
      if (n != 13) continue;
      v_test[n_vec] = t;
      v_op[n_vec]   = op;
      v_mask[n_vec] = m[`ECC_N_INIT-1:0];
      v_addr[n_vec] = {addr_t'(a3), addr_t'(a2), addr_t'(a1), addr_t'(a0)};
      v_data[n_vec] = {d3, d2, d1, d0};
      v_inj[n_vec]  = code_t'(inj);
      v_exp[n_vec]  = int'(ex);
      n_vec++;
    end
    $fclose(fd);
  endtask

  // Responses due now come from reads accepted at the last edge
  task automatic check_resp(int v, logic [`ECC_N_INIT-1:0] due);
    for (int i = 0; i < `ECC_N_INIT; i++) begin
      assert (r_valid[i] == due[i]) else begin
        if (due[i]) $display("test %0d: initiator %0d got no read response", v_test[v], i);
        else $display("ERR r_valid_o[%0d] exp %h got %h", i, due[i], r_valid[i]);
        errors++;
      end
      if (due[i] && r_valid[i] && v_op[v] == OP_RD) begin
        assert (r_rdata[i] == v_data[v][i]) else begin
          $display("ERR r_rdata_o[%0d] exp %h got %h", i, v_data[v][i], r_rdata[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic run_access(int v);
    logic [`ECC_N_INIT-1:0] pending, due, granted;
    logic                   is_rd;
    int                     cycles;
    is_rd   = (v_op[v] != OP_WR);
    pending = v_mask[v];
    due     = '0;
    cycles  = 0;
    @(posedge clk);
    #2;
    addr     = v_addr[v];
    wdata    = v_data[v];
    wen      = {`ECC_N_INIT{is_rd}};
    inj_mask = is_rd ? '0 : v_inj[v];   // Held through the write edge
    req      = pending;
    while (pending != '0 || due != '0) begin
      @(negedge clk);                   // Grant and response settled
      check_resp(v, due);
      if (pending != '0) cycles++;
      assert (pending == '0 || cycles <= 8) else begin
        $display("test %0d: initiators %b never granted", v_test[v], pending);
        errors++;
        pending = '0;
      end
      granted = gnt & pending;
      due     = is_rd ? granted : '0;
      pending &= ~granted;
      @(posedge clk);
      #2;
      req = pending;                    // Winners drop, losers keep asking
    end
    inj_mask = '0;
    wen      = '0;
    if (v_exp[v] != 0) begin
      assert (cycles == v_exp[v]) else begin
        $display("ERR gnt_o cycles exp %h got %h", v_exp[v], cycles);
        errors++;
      end
    end
  endtask

  task automatic read_counter(int v);
    @(posedge clk);
    #2;
    cnt_sel = v_addr[v][0][0];          // 0 correctable, 1 uncorrectable
    @(negedge clk);
    assert (cnt == err_cnt_t'(v_exp[v])) else begin
      $display("ERR cnt_o exp %h got %h", err_cnt_t'(v_exp[v]), cnt);
      errors++;
    end
  endtask

  task automatic report_test(int t, int n_err);
    n_tests++;
    if (n_err != 0) n_failed++;
    $display("test %0d %s (%0d errors)", t, (n_err == 0) ? "passed" : "failed", n_err);
  endtask

  initial begin
    rst_n    = 1'b0;
    req      = '0;
    wen      = '0;
    addr     = '0;
    wdata    = '0;
    inj_mask = '0;
    cnt_sel  = 1'b0;
    cnt_clr  = 1'b0;
    load_vectors();
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;
    cur_test   = (n_vec > 0) ? v_test[0] : 0;
    test_start = total_errors();
    for (int v = 0; v < n_vec; v++) begin
      if (v_test[v] != cur_test) begin
        report_test(cur_test, total_errors() - test_start);
        cur_test   = v_test[v];
        test_start = total_errors();
      end
      case (v_op[v])
        OP_WR, OP_RD, OP_RDX: run_access(v);
        OP_CNT: read_counter(v);
        OP_CLR: begin
          @(posedge clk);
          #2 cnt_clr = 1'b1;            // One-cycle clear pulse
          @(posedge clk);
          #2 cnt_clr = 1'b0;
        end
        default: begin
          $display("Vector %0d has unknown operation %0d", v, v_op[v]);
          errors++;
        end
      endcase
    end
    if (n_vec > 0) report_test(cur_test, total_errors() - test_start);
    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
    if (n_vec > 0 && total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Budget of 30 cycles per vector line
  initial begin
    wait (n_vec > 0);
    #(n_vec * 30 * 20);
    $display("Watchdog expired after %0d vector lines", n_vec);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: tb/ecc_icon_stim.txt
# test op initmask addr0 addr1 addr2 addr3 data0 data1 data2 data3 injmask expect
# op 0 write, 1 read, 2 read unchecked, 3 counter (addr0 selects), 4 clear; expect is grant cycles or count
1 0 f 04 09 0e 13 11110000 22221111 33332222 44443333 0000000000 1
1 0 f 17 14 19 1e 5555aaaa 6666bbbb 7777cccc 8888dddd 0000000000 1
1 1 1 04 00 00 00 11110000 00000000 00000000 00000000 0000000000 1
1 1 2 00 14 00 00 00000000 6666bbbb 00000000 00000000 0000000000 1
1 1 4 00 00 0e 00 00000000 00000000 33332222 00000000 0000000000 1
1 1 8 00 00 00 1e 00000000 00000000 00000000 8888dddd 0000000000 1
2 1 f 17 09 04 0e 5555aaaa 22221111 11110000 33332222 0000000000 1
3 1 3 0e 1e 00 00 33332222 8888dddd 00000000 00000000 0000000000 2
3 1 c 00 00 09 19 00000000 00000000 22221111 7777cccc 0000000000 2
4 3 0 00 00 00 00 00000000 00000000 00000000 00000000 0000000000 0
4 0 1 21 00 00 00 cafef00d 00000000 00000000 00000000 0000000008 1
4 1 1 21 00 00 00 cafef00d 00000000 00000000 00000000 0000000000 1
4 3 0 00 00 00 00 00000000 00000000 00000000 00000000 0000000000 1
4 3 0 01 00 00 00 00000000 00000000 00000000 00000000 0000000000 0
5 0 2 00 22 00 00 00000000 deadbeef 00000000 00000000 0000000030 1
5 2 2 00 22 00 00 00000000 00000000 00000000 00000000 0000000000 1
5 3 0 01 00 00 00 00000000 00000000 00000000 00000000 0000000000 1
5 3 0 00 00 00 00 00000000 00000000 00000000 00000000 0000000000 1
6 4 0 00 00 00 00 00000000 00000000 00000000 00000000 0000000000 0
6 3 0 00 00 00 00 00000000 00000000 00000000 00000000 0000000000 0
6 3 0 01 00 00 00 00000000 00000000 00000000 00000000 0000000000 0

// File: ecc_icon_top.f
+incdir+logic
logic/ecc_icon_pkg.sv
logic/ecc_xbar_req.sv
logic/ecc_bank.sv
logic/ecc_resp_collect.sv
logic/ecc_icon_top.sv
tb/ecc_icon_chk.sv
tb/tb_ecc_icon_top.sv
